/* filelist.f */
src/fxpDecimPkg.sv
src/decimControl.sv
src/coeffBank.sv
src/sampleWindow.sv
src/lutSumUnit.sv
src/outputFormatter.sv
src/fxpDecimTop.sv
verif/tbClockGen.sv
verif/fxpDecimTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decimator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module fxpDecimTb \
    -Mdir obj_dir -o simv

./obj_dir/simv | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"

/* src/coeffBank.sv */
`timescale 1ns/1ps

module coeffBank (
    input  logic                                      clkDS,
    input  logic                                      rst,
    input  logic                                      wrEn,
    input  logic [4:0]                                wrAdr,
    input  logic signed [fxpDecimPkg::CoeffWidth-1:0] wrData,
    input  logic [4:0]                                rdAdr,
    output logic signed [fxpDecimPkg::CoeffWidth-1:0] rdData,
    output logic [fxpDecimPkg::LookaheadTaps*fxpDecimPkg::CoeffWidth-1:0] lookaheadCoeffs,
    output logic [fxpDecimPkg::LookbackTaps*fxpDecimPkg::CoeffWidth-1:0]  lookbackCoeffs
);

    logic signed [fxpDecimPkg::CoeffWidth-1:0] coeff [fxpDecimPkg::TotalTaps];

    always_ff @(posedge clkDS) begin
        if (rst) begin
            for (int i = 0; i < fxpDecimPkg::TotalTaps; i++) begin
                coeff[i] <= '0;
            end
        end else if (wrEn) begin
            coeff[wrAdr] <= wrData;
        end
    end

    assign rdData = coeff[rdAdr];

    // Lookahead taps sit at the low addresses, lookback right above
    always_comb begin
        for (int k = 0; k < fxpDecimPkg::LookaheadTaps; k++) begin
            lookaheadCoeffs[k*fxpDecimPkg::CoeffWidth +: fxpDecimPkg::CoeffWidth] = coeff[k];
        end
        for (int k = 0; k < fxpDecimPkg::LookbackTaps; k++) begin
            lookbackCoeffs[k*fxpDecimPkg::CoeffWidth +: fxpDecimPkg::CoeffWidth] =
                coeff[fxpDecimPkg::LookaheadTaps + k];
        end
    end

endmodule

/* src/decimControl.sv */
`timescale 1ns/1ps

module decimControl (
    input  logic                                       clkDS,
    input  logic                                       rst,
    input  logic                                       wbCyc,
    input  logic                                       wbStb,
    input  logic                                       wbWe,
    input  logic [fxpDecimPkg::WbAdrWidth-1:0]         wbAdr,
    input  logic [fxpDecimPkg::WbDataWidth-1:0]        wbDatW,
    output logic [fxpDecimPkg::WbDataWidth-1:0]        wbDatR,
    output logic                                       wbAck,
    input  logic signed [fxpDecimPkg::CoeffWidth-1:0]  coeffRdData,
    output logic                                       coeffWrEn,
    output logic [4:0]                                 coeffWrAdr,
    output logic signed [fxpDecimPkg::CoeffWidth-1:0]  coeffWrData,
    output logic                                       shiftEn,
    output logic                                       pipeEn,
    output logic                                       outValid
);

    logic access;
    logic isCoeff;
    logic isCtrl;
    logic isStatus;
    logic enable;
    logic windowFull;
    logic [fxpDecimPkg::WbDataWidth-1:0] rdMux;
    logic [$clog2(fxpDecimPkg::WindowWords + 1)-1:0] fillCount;
    logic [fxpDecimPkg::TreeLatency + fxpDecimPkg::FormatLatency:0] validPipe;

    // New access only while ack is low, so ack lasts one cycle
    assign access = wbCyc && wbStb && !wbAck;
    assign isCoeff = !wbAdr[fxpDecimPkg::WbAdrWidth-1];
    assign isCtrl = (wbAdr == fxpDecimPkg::WbAdrWidth'(fxpDecimPkg::AdrCtrl));
    assign isStatus = (wbAdr == fxpDecimPkg::WbAdrWidth'(fxpDecimPkg::AdrStatus));

    assign coeffWrEn = access && wbWe && isCoeff;
    assign coeffWrAdr = wbAdr[4:0];
    assign coeffWrData = wbDatW[fxpDecimPkg::CoeffWidth-1:0];

    always_ff @(posedge clkDS) begin
        if (rst) begin
            wbAck <= 1'b0;
            enable <= 1'b0;
        end else begin
            wbAck <= access;
            if (access && wbWe && isCtrl) begin
                enable <= wbDatW[0];
            end
        end
    end

    always_comb begin
        rdMux = '0;
        if (isCoeff) begin
            rdMux = {{(fxpDecimPkg::WbDataWidth - fxpDecimPkg::CoeffWidth)
                      {coeffRdData[fxpDecimPkg::CoeffWidth-1]}}, coeffRdData};
        end else if (isCtrl) begin
            rdMux[0] = enable;
        end else if (isStatus) begin
            rdMux[0] = outValid;
        end
    end

    // Read data captured on the edge that raises ack
    always_ff @(posedge clkDS) begin
        if (access) begin
            wbDatR <= rdMux;
        end
    end

    assign shiftEn = enable;
    assign pipeEn = enable;

    // Window holds only fresh words once this edge brings the count to full
    assign windowFull = (fillCount >= ($bits(fillCount))'(fxpDecimPkg::WindowWords - 1));

    always_ff @(posedge clkDS) begin
        if (rst || !enable) begin
            fillCount <= '0;
            validPipe <= '0;
        end else begin
            if (fillCount != ($bits(fillCount))'(fxpDecimPkg::WindowWords)) begin
                fillCount <= fillCount + 1'b1;
            end
            validPipe <= {validPipe[$bits(validPipe)-2:0], windowFull};
        end
    end

    assign outValid = validPipe[$bits(validPipe)-1];

endmodule

/* src/fxpDecimPkg.sv */
package fxpDecimPkg;

    // Modulator bits delivered per clkDS cycle
    localparam int DecimRatio = 8;

    localparam int LookaheadTaps = 16;
    localparam int LookbackTaps = 16;
    localparam int TotalTaps = LookaheadTaps + LookbackTaps;
    localparam int WindowWords = TotalTaps / DecimRatio;

    localparam int CoeffWidth = 14;

    // Partial-sum grouping, one LUT-equivalent per group
    localparam int LutSize = 4;
    localparam int LutGroups = LookaheadTaps / LutSize;

    localparam int HalfSumWidth = 19;
    localparam int SumWidth = 20;

    localparam int OutWidth = 12;
    localparam int OutShift = 7;

    localparam int TreeLatency = 3;
    localparam int FormatLatency = 2;

    // Wishbone side
    localparam int WbAdrWidth = 6;
    localparam int WbDataWidth = 32;
    localparam int AdrCtrl = 32;
    localparam int AdrStatus = 33;

endpackage

/* src/fxpDecimTop.sv */
`timescale 1ns/1ps

module fxpDecimTop (
    input  logic                                 clkDS,
    input  logic                                 rst,
    input  logic                                 wbCyc,
    input  logic                                 wbStb,
    input  logic                                 wbWe,
    input  logic [fxpDecimPkg::WbAdrWidth-1:0]   wbAdr,
    input  logic [fxpDecimPkg::WbDataWidth-1:0]  wbDatW,
    output logic [fxpDecimPkg::WbDataWidth-1:0]  wbDatR,
    output logic                                 wbAck,
    input  logic [fxpDecimPkg::DecimRatio-1:0]   sampleIn,
    output logic [fxpDecimPkg::OutWidth-1:0]     pcmOut,
    output logic                                 outValid
);

    logic signed [fxpDecimPkg::CoeffWidth-1:0] coeffRdData;
    logic signed [fxpDecimPkg::CoeffWidth-1:0] coeffWrData;
    logic coeffWrEn;
    logic [4:0] coeffWrAdr;
    logic shiftEn;
    logic pipeEn;

    logic [fxpDecimPkg::LookaheadTaps*fxpDecimPkg::CoeffWidth-1:0] lookaheadCoeffs;
    logic [fxpDecimPkg::LookbackTaps*fxpDecimPkg::CoeffWidth-1:0] lookbackCoeffs;
    logic [fxpDecimPkg::LookaheadTaps-1:0] aheadBits;
    logic [fxpDecimPkg::LookbackTaps-1:0] backBits;
    logic signed [fxpDecimPkg::HalfSumWidth-1:0] aheadSum;
    logic signed [fxpDecimPkg::HalfSumWidth-1:0] backSum;

    decimControl u_control (
        .clkDS(clkDS),
        .rst(rst),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .coeffRdData(coeffRdData),
        .coeffWrEn(coeffWrEn),
        .coeffWrAdr(coeffWrAdr),
        .coeffWrData(coeffWrData),
        .shiftEn(shiftEn),
        .pipeEn(pipeEn),
        .outValid(outValid)
    );

    // Bus reads share the low address bits with writes
    coeffBank u_coeffs (
        .clkDS(clkDS),
        .rst(rst),
        .wrEn(coeffWrEn),
        .wrAdr(coeffWrAdr),
        .wrData(coeffWrData),
        .rdAdr(wbAdr[4:0]),
        .rdData(coeffRdData),
        .lookaheadCoeffs(lookaheadCoeffs),
        .lookbackCoeffs(lookbackCoeffs)
    );

    sampleWindow u_window (
        .clkDS(clkDS),
        .rst(rst),
        .shiftEn(shiftEn),
        .sampleIn(sampleIn),
        .aheadBits(aheadBits),
        .backBits(backBits)
    );

    lutSumUnit aheadLut (
        .clkDS(clkDS),
        .rst(rst),
        .pipeEn(pipeEn),
        .bits(aheadBits),
        .coeffs(lookaheadCoeffs),
        .halfSum(aheadSum)
    );

    lutSumUnit backLut (
        .clkDS(clkDS),
        .rst(rst),
        .pipeEn(pipeEn),
        .bits(backBits),
        .coeffs(lookbackCoeffs),
        .halfSum(backSum)
    );

    outputFormatter u_format (
        .clkDS(clkDS),
        .rst(rst),
        .pipeEn(pipeEn),
        .aheadSum(aheadSum),
        .backSum(backSum),
        .pcmOut(pcmOut)
    );

endmodule

/* src/lutSumUnit.sv */
`timescale 1ns/1ps

// Both window halves have the same tap count
module lutSumUnit (
    input  logic                                        clkDS,
    input  logic                                        rst,
    input  logic                                        pipeEn,
    input  logic [fxpDecimPkg::LookaheadTaps-1:0]       bits,
    input  logic [fxpDecimPkg::LookaheadTaps*fxpDecimPkg::CoeffWidth-1:0] coeffs,
    output logic signed [fxpDecimPkg::HalfSumWidth-1:0] halfSum
);

    logic signed [fxpDecimPkg::HalfSumWidth-1:0] groupSum [fxpDecimPkg::LutGroups];
    logic signed [fxpDecimPkg::HalfSumWidth-1:0] pairSum [fxpDecimPkg::LutGroups/2];

    // What a LUT addressed by the group bits would hold
    function automatic logic signed [fxpDecimPkg::HalfSumWidth-1:0] lutEntry(
        input logic [fxpDecimPkg::LutSize-1:0] sel,
        input logic [fxpDecimPkg::LutSize*fxpDecimPkg::CoeffWidth-1:0] taps
    );
        logic signed [fxpDecimPkg::HalfSumWidth-1:0] acc;
        logic signed [fxpDecimPkg::HalfSumWidth-1:0] tap;
        acc = '0;
        for (int j = 0; j < fxpDecimPkg::LutSize; j++) begin
            tap = fxpDecimPkg::HalfSumWidth'(
                $signed(taps[j*fxpDecimPkg::CoeffWidth +: fxpDecimPkg::CoeffWidth]));
            // Bit 1 adds, bit 0 subtracts
            if (sel[j]) begin
                acc = acc + tap;
            end else begin
                acc = acc - tap;
            end
        end
        return acc;
    endfunction

    always_ff @(posedge clkDS) begin
        if (rst) begin
            for (int g = 0; g < fxpDecimPkg::LutGroups; g++) begin
                groupSum[g] <= '0;
            end
            for (int p = 0; p < fxpDecimPkg::LutGroups/2; p++) begin
                pairSum[p] <= '0;
            end
            halfSum <= '0;
        end else if (pipeEn) begin
            for (int g = 0; g < fxpDecimPkg::LutGroups; g++) begin
                groupSum[g] <= lutEntry(
                    bits[g*fxpDecimPkg::LutSize +: fxpDecimPkg::LutSize],
                    coeffs[g*fxpDecimPkg::LutSize*fxpDecimPkg::CoeffWidth +:
                           fxpDecimPkg::LutSize*fxpDecimPkg::CoeffWidth]);
            end
            // Adder tree, one level per cycle
            for (int p = 0; p < fxpDecimPkg::LutGroups/2; p++) begin
                pairSum[p] <= groupSum[2*p] + groupSum[2*p+1];
            end
            halfSum <= pairSum[0] + pairSum[1];
        end
    end

endmodule

/* src/outputFormatter.sv */
`timescale 1ns/1ps

module outputFormatter (
    input  logic                                        clkDS,
    input  logic                                        rst,
    input  logic                                        pipeEn,
    input  logic signed [fxpDecimPkg::HalfSumWidth-1:0] aheadSum,
    input  logic signed [fxpDecimPkg::HalfSumWidth-1:0] backSum,
    output logic [fxpDecimPkg::OutWidth-1:0]            pcmOut
);

    logic signed [fxpDecimPkg::SumWidth-1:0] sumReg;
    logic signed [fxpDecimPkg::SumWidth-1:0] shifted;
    logic [fxpDecimPkg::SumWidth-fxpDecimPkg::OutWidth:0] upperBits;
    logic signed [fxpDecimPkg::OutWidth-1:0] satVal;

    always_ff @(posedge clkDS) begin
        if (rst) begin
            sumReg <= '0;
        end else if (pipeEn) begin
            sumReg <= fxpDecimPkg::SumWidth'(aheadSum) + fxpDecimPkg::SumWidth'(backSum);
        end
    end

    assign shifted = sumReg >>> fxpDecimPkg::OutShift;
    assign upperBits = shifted[fxpDecimPkg::SumWidth-1:fxpDecimPkg::OutWidth-1];

    // Out of range when the bits above the output sign disagree
    always_comb begin
        if ((&upperBits) || !(|upperBits)) begin
            satVal = shifted[fxpDecimPkg::OutWidth-1:0];
        end else if (shifted[fxpDecimPkg::SumWidth-1]) begin
            satVal = {1'b1, {(fxpDecimPkg::OutWidth-1){1'b0}}};
        end else begin
            satVal = {1'b0, {(fxpDecimPkg::OutWidth-1){1'b1}}};
        end
    end

    // Offset binary
    always_ff @(posedge clkDS) begin
        if (rst) begin
            pcmOut <= '0;
        end else if (pipeEn) begin
            pcmOut <= {~satVal[fxpDecimPkg::OutWidth-1], satVal[fxpDecimPkg::OutWidth-2:0]};
        end
    end

endmodule

/* src/sampleWindow.sv */
`timescale 1ns/1ps

module sampleWindow (
    input  logic                                   clkDS,
    input  logic                                   rst,
    input  logic                                   shiftEn,
    input  logic [fxpDecimPkg::DecimRatio-1:0]     sampleIn,
    output logic [fxpDecimPkg::LookaheadTaps-1:0]  aheadBits,
    output logic [fxpDecimPkg::LookbackTaps-1:0]   backBits
);

    logic [fxpDecimPkg::TotalTaps-1:0] window;

    // Newest word enters at the bottom
    always_ff @(posedge clkDS) begin
        if (rst) begin
            window <= '0;
        end else if (shiftEn) begin
            window <= {window[fxpDecimPkg::TotalTaps-fxpDecimPkg::DecimRatio-1:0], sampleIn};
        end
    end

    assign backBits = window[fxpDecimPkg::TotalTaps-1:fxpDecimPkg::LookaheadTaps];

    // Reverse the lookahead half so index 0 borders the lookback half
    always_comb begin
        for (int i = 0; i < fxpDecimPkg::LookaheadTaps; i++) begin
            aheadBits[i] = window[fxpDecimPkg::LookaheadTaps-1-i];
        end
    end

endmodule

/* verif/fxpDecimTb.sv */
`timescale 1ns/1ps

module fxpDecimTb;

    localparam int AckLimit = 10;
    localparam int ValidLimit = 40;
    localparam int ResetLimit = 40;
    localparam int PipeDepth = fxpDecimPkg::TreeLatency + fxpDecimPkg::FormatLatency + 1;
    localparam int FillDelay = fxpDecimPkg::WindowWords + PipeDepth - 1;

    logic clkDS;
    logic rst;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [fxpDecimPkg::WbAdrWidth-1:0] wbAdr;
    logic [fxpDecimPkg::WbDataWidth-1:0] wbDatW;
    logic [fxpDecimPkg::WbDataWidth-1:0] wbDatR;
    logic wbAck;
    logic [fxpDecimPkg::DecimRatio-1:0] sampleIn;
    logic [fxpDecimPkg::OutWidth-1:0] pcmOut;
    logic outValid;

    // Model of accepted words (index 0 newest) and of the coefficient bank
    logic [fxpDecimPkg::DecimRatio-1:0] wordModel [fxpDecimPkg::WindowWords];
    int coeffModel [fxpDecimPkg::TotalTaps];
    logic enModel = 1'b0;
    int fillModel = 0;
    logic [fxpDecimPkg::OutWidth-1:0] expDelay [PipeDepth];
    logic validDelay [PipeDepth];
    logic ackPrev = 1'b0;
    int errCount = 0;
    int checkCount = 0;

    tbClockGen u_clk (
        .clkDS(clkDS),
        .rst(rst)
    );

    fxpDecimTop u_dut (
        .clkDS(clkDS),
        .rst(rst),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .sampleIn(sampleIn),
        .pcmOut(pcmOut),
        .outValid(outValid)
    );

    // Expected output word for one 32-bit window
    function automatic logic [fxpDecimPkg::OutWidth-1:0] refPcm(
        input logic [fxpDecimPkg::DecimRatio-1:0] words [fxpDecimPkg::WindowWords],
        input int coeffs [fxpDecimPkg::TotalTaps]
    );
        logic [fxpDecimPkg::TotalTaps-1:0] win;
        int acc;
        int scaled;
        int maxOut;
        int minOut;
        win = {words[3], words[2], words[1], words[0]};
        maxOut = (1 << (fxpDecimPkg::OutWidth - 1)) - 1;
        minOut = -(1 << (fxpDecimPkg::OutWidth - 1));
        acc = 0;
        for (int k = 0; k < fxpDecimPkg::LookaheadTaps; k++) begin
            // Lookahead tap k counts down from the half boundary, lookback counts up
            acc += win[15 - k] ? coeffs[k] : -coeffs[k];
            acc += win[16 + k] ? coeffs[16 + k] : -coeffs[16 + k];
        end
        scaled = acc >>> fxpDecimPkg::OutShift;
        if (scaled > maxOut) begin
            scaled = maxOut;
        end else if (scaled < minOut) begin
            scaled = minOut;
        end
        return {~scaled[fxpDecimPkg::OutWidth-1], scaled[fxpDecimPkg::OutWidth-2:0]};
    endfunction

    // Model advances on the same edges as the DUT pipeline
    always @(posedge clkDS) begin
        if (rst) begin
            for (int i = 0; i < fxpDecimPkg::WindowWords; i++) begin
                wordModel[i] = '0;
            end
            fillModel = 0;
            for (int i = 0; i < PipeDepth; i++) begin
                expDelay[i] = '0;
                validDelay[i] = 1'b0;
            end
        end else if (enModel) begin
            for (int i = fxpDecimPkg::WindowWords - 1; i > 0; i--) begin
                wordModel[i] = wordModel[i-1];
            end
            wordModel[0] = sampleIn;
            if (fillModel < fxpDecimPkg::WindowWords) begin
                fillModel++;
            end
            for (int i = PipeDepth - 1; i > 0; i--) begin
                expDelay[i] = expDelay[i-1];
                validDelay[i] = validDelay[i-1];
            end
            expDelay[0] = refPcm(wordModel, coeffModel);
            validDelay[0] = (fillModel == fxpDecimPkg::WindowWords);
        end else begin
            fillModel = 0;
            for (int i = 0; i < PipeDepth; i++) begin
                validDelay[i] = 1'b0;
            end
        end
    end

    always @(negedge clkDS) begin
        if (!rst) begin
            checkCount++;
            assert (outValid === validDelay[PipeDepth-1]) else begin
                $display("error: outValid is %h, expected %h", outValid,
                         validDelay[PipeDepth-1]);
                errCount++;
            end
            // Ack lasts a single cycle
            checkCount++;
            assert (!(ackPrev && wbAck)) else begin
                $display("error: wbAck is %h, expected %h", wbAck, 1'b0);
                errCount++;
            end
            ackPrev = wbAck;
            if (validDelay[PipeDepth-1]) begin
                checkCount++;
                assert (pcmOut === expDelay[PipeDepth-1]) else begin
                    $display("error: pcmOut is %h, expected %h", pcmOut,
                             expDelay[PipeDepth-1]);
                    errCount++;
                end
            end
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        assert (got === expected) else begin
            $display("error: %s is %h, expected %h", name, got, expected);
            errCount++;
        end
    endtask

    task automatic reportTest(input int num, input string name, input int mark);
        if (errCount == mark) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errCount - mark);
        end
    endtask

    task automatic waitReset();
        int n;
        n = 0;
        do begin
            @(negedge clkDS);
            n++;
            if (n > ResetLimit) abortRun("reset was never released");
        end while (rst);
    endtask

    task automatic busWrite(input int adr, input logic [31:0] data);
        int n;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b1;
        wbAdr = fxpDecimPkg::WbAdrWidth'(adr);
        wbDatW = data;
        n = 0;
        do begin
            @(negedge clkDS);
            n++;
            if (n > AckLimit) abortRun("wbAck never came for a bus write");
        end while (!wbAck);
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        // Write landed on the edge that raised ack
        if (adr < fxpDecimPkg::TotalTaps) begin
            coeffModel[adr] = $signed(data[fxpDecimPkg::CoeffWidth-1:0]);
        end else if (adr == fxpDecimPkg::AdrCtrl) begin
            enModel = data[0];
        end
    endtask

    task automatic busRead(input int adr, output logic [31:0] data);
        int n;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b0;
        wbAdr = fxpDecimPkg::WbAdrWidth'(adr);
        n = 0;
        do begin
            @(negedge clkDS);
            n++;
            if (n > AckLimit) abortRun("wbAck never came for a bus read");
        end while (!wbAck);
        data = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    task automatic driveWords(input int count, input logic randomFill,
                              input logic [7:0] word);
        for (int i = 0; i < count; i++) begin
            sampleIn = randomFill ? 8'($urandom()) : word;
            @(negedge clkDS);
        end
    endtask

    // Random words keep flowing while outValid is awaited
    task automatic waitValid(output int cycles);
        cycles = 0;
        do begin
            sampleIn = 8'($urandom());
            @(negedge clkDS);
            cycles++;
            if (cycles > ValidLimit) abortRun("outValid did not rise after enable");
        end while (!outValid);
    endtask

    task automatic loadRandomCoeffs();
        for (int a = 0; a < fxpDecimPkg::TotalTaps; a++) begin
            busWrite(a, $urandom());
        end
    endtask

    task automatic loadSameCoeff(input logic [31:0] value);
        for (int a = 0; a < fxpDecimPkg::TotalTaps; a++) begin
            busWrite(a, value);
        end
    endtask

    initial begin
        int mark;
        int cycles;
        logic [31:0] rdVal;
        void'($urandom(88222));
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        sampleIn = '0;
        waitReset();

        mark = errCount;
        for (int a = 0; a < fxpDecimPkg::TotalTaps; a++) begin
            busRead(a, rdVal);
            checkValue("wbDatR", rdVal, 32'h0);
        end
        busRead(fxpDecimPkg::AdrCtrl, rdVal);
        checkValue("wbDatR", rdVal, 32'h0);
        busRead(fxpDecimPkg::AdrStatus, rdVal);
        checkValue("wbDatR", rdVal, 32'h0);
        checkValue("pcmOut", 32'(pcmOut), 32'h0);
        reportTest(1, "reset state", mark);

        mark = errCount;
        loadRandomCoeffs();
        busWrite(fxpDecimPkg::AdrStatus, 32'h1);
        for (int a = 0; a < fxpDecimPkg::TotalTaps; a++) begin
            busRead(a, rdVal);
            checkValue("wbDatR", rdVal, 32'(coeffModel[a]));
        end
        busRead(fxpDecimPkg::AdrStatus, rdVal);
        checkValue("wbDatR", rdVal, 32'h0);
        reportTest(2, "coefficient readback", mark);

        // Every tap has its own weight, so a misplaced bit shows in the sum
        mark = errCount;
        for (int a = 0; a < fxpDecimPkg::TotalTaps; a++) begin
            busWrite(a, 32'((a + 1) * 128));
        end
        busWrite(fxpDecimPkg::AdrCtrl, 32'h1);
        driveWords(fxpDecimPkg::WindowWords + 2, 1'b0, 8'h00);
        for (int p = 0; p < fxpDecimPkg::DecimRatio; p++) begin
            driveWords(1, 1'b0, 8'(1 << p));
            driveWords(fxpDecimPkg::WindowWords, 1'b0, 8'h00);
        end
        driveWords(PipeDepth, 1'b0, 8'h00);
        busWrite(fxpDecimPkg::AdrCtrl, 32'h0);
        reportTest(3, "walking bit", mark);

        mark = errCount;
        loadRandomCoeffs();
        busWrite(fxpDecimPkg::AdrCtrl, 32'h1);
        waitValid(cycles);
        checkValue("outValid delay", 32'(cycles), 32'(FillDelay));
        driveWords(200, 1'b1, 8'h00);
        busWrite(fxpDecimPkg::AdrCtrl, 32'h0);
        reportTest(4, "random stream", mark);

        mark = errCount;
        loadSameCoeff(32'h0000_1FFF);
        busWrite(fxpDecimPkg::AdrCtrl, 32'h1);
        driveWords(FillDelay + 1, 1'b0, 8'hFF);
        checkValue("pcmOut", 32'(pcmOut), 32'hFFF);
        driveWords(FillDelay + 1, 1'b0, 8'h00);
        checkValue("pcmOut", 32'(pcmOut), 32'h000);
        busWrite(fxpDecimPkg::AdrCtrl, 32'h0);
        // Most negative taps drive the sum past the positive limit
        loadSameCoeff(32'h0000_2000);
        busWrite(fxpDecimPkg::AdrCtrl, 32'h1);
        driveWords(FillDelay + 1, 1'b0, 8'h00);
        checkValue("pcmOut", 32'(pcmOut), 32'hFFF);
        driveWords(FillDelay + 1, 1'b0, 8'hFF);
        checkValue("pcmOut", 32'(pcmOut), 32'h000);
        busWrite(fxpDecimPkg::AdrCtrl, 32'h0);
        reportTest(5, "saturation", mark);

        mark = errCount;
        loadRandomCoeffs();
        busWrite(fxpDecimPkg::AdrCtrl, 32'h1);
        waitValid(cycles);
        driveWords(20, 1'b1, 8'h00);
        busRead(fxpDecimPkg::AdrStatus, rdVal);
        checkValue("wbDatR", rdVal, 32'h1);
        busRead(fxpDecimPkg::AdrCtrl, rdVal);
        checkValue("wbDatR", rdVal, 32'h1);
        busWrite(fxpDecimPkg::AdrCtrl, 32'h0);
        driveWords(3, 1'b1, 8'h00);
        checkValue("outValid", 32'(outValid), 32'h0);
        busWrite(fxpDecimPkg::AdrCtrl, 32'h1);
        waitValid(cycles);
        checkValue("outValid delay", 32'(cycles), 32'(FillDelay));
        driveWords(50, 1'b1, 8'h00);
        busWrite(fxpDecimPkg::AdrCtrl, 32'h0);
        reportTest(6, "enable toggle", mark);

        $display("summary: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verif/tbClockGen.sv */
`timescale 1ns/1ps

module tbClockGen (
    output logic clkDS,
    output logic rst
);

    // 8 ns period
    initial begin
        clkDS = 1'b0;
        forever begin
            #4 clkDS = ~clkDS;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clkDS);
        @(negedge clkDS);
        rst <= 1'b0;
    end

endmodule
